// File: rtl/netdbg_pkg.sv
`default_nettype none

package netdbg_pkg;

	//////////////////////////////
	// widths and constants
	//////////////////////////////

	// bus data word and word address
	localparam int DW = 32;
	localparam int ADDR_W = 30;

	// reply data for a read that failed on the bus or timed out
	localparam logic [DW-1:0] ERR_WORD = 32'hDEADBEEF;

	//////////////////////////////
	// opcodes
	//////////////////////////////

	// request command opcode, found in bits 31:30 of each command word
	typedef enum logic [1:0] {
		REQ_SET_ADDR = 2'b00,
		REQ_WRITE    = 2'b01,
		REQ_READ     = 2'b10,
		REQ_NOP      = 2'b11
	} req_op_e;

	// command FIFO entry kinds
	typedef enum logic [1:0] {
		CMD_HEADER,
		CMD_WRITE,
		CMD_READ,
		CMD_END
	} cmd_op_e;

	//////////////////////////////
	// bundles
	//////////////////////////////

	// one command entry
	// for CMD_HEADER, data is frame id in 31:16 and gpio outputs in 7:0
	typedef struct packed {
		cmd_op_e             op;
		logic [ADDR_W-1:0]   addr;
		logic [DW-1:0]       data;
	} cmd_entry_t;

	// one beat of either packet stream
	typedef struct packed {
		logic [DW-1:0]       data;
		logic                last;
	} stream_beat_t;

	// wishbone master outputs, sel is always all ones
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [ADDR_W-1:0]   addr;
		logic [DW-1:0]       data;
	} wb_req_t;

	// wishbone slave responses
	typedef struct packed {
		logic                stall;
		logic                ack;
		logic                err;
		logic [DW-1:0]       data;
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: rtl/netdbg_parser.sv
`timescale 1ns/1ps
`default_nettype none

module netdbg_parser #(
	parameter logic [7:0] DEF_GPIO = 8'h00
) (
	input  wire                           i_clk,
	input  wire                           i_reset,
	// request stream
	input  netdbg_pkg::stream_beat_t      i_req,
	input  wire                           i_req_valid,
	output logic                          o_req_ready,
	// gpio outputs
	output logic [7:0]                    o_gpio,
	// command FIFO write side
	output logic                          o_push,
	output netdbg_pkg::cmd_entry_t        o_entry,
	input  wire                           i_full
);

	// where we are inside the request packet
	typedef enum logic [1:0] {
		ST_HEADER,
		ST_CMD,
		ST_WDATA,
		ST_END
	} parse_state_e;

	parse_state_e                     r_state;
	logic [netdbg_pkg::ADDR_W-1:0]    r_addr;
	logic                             w_accept;
	netdbg_pkg::req_op_e              w_op;
	logic [7:0]                       w_new_gpio;

	// no word is taken in reset, in the CMD_END slot or while the FIFO is full
	assign o_req_ready = !i_reset && !i_full && (r_state != ST_END);
	assign w_accept = i_req_valid && o_req_ready;

	assign w_op = netdbg_pkg::req_op_e'(i_req.data[31:30]);

	// masked bits take the header value, the rest hold
	assign w_new_gpio = (o_gpio & ~i_req.data[15:8]) | (i_req.data[7:0] & i_req.data[15:8]);

	//////////////////////////////
	// entry generation
	//////////////////////////////

	always_comb
	begin
		o_push = 1'b0;
		o_entry.op = netdbg_pkg::CMD_END;
		o_entry.addr = r_addr;
		o_entry.data = i_req.data;
		case (r_state)
		ST_HEADER:
		begin
			// header entry goes out in the same cycle as the word
			o_push = w_accept;
			o_entry.op = netdbg_pkg::CMD_HEADER;
			o_entry.data = {i_req.data[31:16], 8'h00, w_new_gpio};
		end
		ST_CMD:
		begin
			// only reads push here, a write waits for its data word
			o_push = w_accept && (w_op == netdbg_pkg::REQ_READ);
			o_entry.op = netdbg_pkg::CMD_READ;
		end
		ST_WDATA:
		begin
			o_push = w_accept;
			o_entry.op = netdbg_pkg::CMD_WRITE;
		end
		default:
		begin
			// packet closer, written once there is room
			o_push = !i_full;
		end
		endcase
	end

	//////////////////////////////
	// state, address and gpio
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_state <= ST_HEADER;
			r_addr <= '0;
			o_gpio <= DEF_GPIO;
		end
		else
		begin
			case (r_state)
			ST_HEADER:
			begin
				if (w_accept)
				begin
					o_gpio <= w_new_gpio;
					r_state <= i_req.last ? ST_END : ST_CMD;
				end
			end
			ST_CMD:
			begin
				if (w_accept)
				begin
					r_state <= i_req.last ? ST_END : ST_CMD;
					if (w_op == netdbg_pkg::REQ_SET_ADDR)
						r_addr <= i_req.data[netdbg_pkg::ADDR_W-1:0];
					else if (w_op == netdbg_pkg::REQ_READ)
						r_addr <= r_addr + 1'b1;
					// a write with no data word behind it is dropped
					else if ((w_op == netdbg_pkg::REQ_WRITE) && !i_req.last)
						r_state <= ST_WDATA;
				end
			end
			ST_WDATA:
			begin
				if (w_accept)
				begin
					r_addr <= r_addr + 1'b1;
					r_state <= i_req.last ? ST_END : ST_CMD;
				end
			end
			default:
			begin
				if (!i_full)
					r_state <= ST_HEADER;
			end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/netdbg_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module netdbg_cmd_fifo #(
	parameter int LG_FIFO = 4
) (
	input  wire                           i_clk,
	input  wire                           i_reset,
	// write side
	input  wire                           i_push,
	input  netdbg_pkg::cmd_entry_t        i_entry,
	output logic                          o_full,
	// read side
	input  wire                           i_pop,
	output netdbg_pkg::cmd_entry_t        o_entry,
	output logic                          o_empty
);

	localparam int DEPTH = 1 << LG_FIFO;

	// storage, payload only
	netdbg_pkg::cmd_entry_t   r_mem [0:DEPTH-1];

	// pointers with one extra wrap bit on top
	logic [LG_FIFO:0]         r_wptr;
	logic [LG_FIFO:0]         r_rptr;

	//////////////////////////////
	// storage
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_push)
			r_mem[r_wptr[LG_FIFO-1:0]] <= i_entry;
	end

	// head entry shows on the read side right after the write edge
	assign o_entry = r_mem[r_rptr[LG_FIFO-1:0]];

	//////////////////////////////
	// pointers
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_wptr <= '0;
			r_rptr <= '0;
		end
		else
		begin
			if (i_push)
				r_wptr <= r_wptr + 1'b1;
			if (i_pop)
				r_rptr <= r_rptr + 1'b1;
		end
	end

	// same slot, wrap bits differ means full
	assign o_full = (r_wptr[LG_FIFO] != r_rptr[LG_FIFO])
		&& (r_wptr[LG_FIFO-1:0] == r_rptr[LG_FIFO-1:0]);
	assign o_empty = (r_wptr == r_rptr);

	// parser never pushes into a full FIFO
	a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset)
		i_push |-> !o_full);

	// executor only pops what is there
	a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset)
		i_pop |-> !o_empty);

endmodule

`default_nettype wire

// File: rtl/netdbg_bus_exec.sv
`timescale 1ns/1ps
`default_nettype none

module netdbg_bus_exec #(
	parameter int WDT_LG = 8
) (
	input  wire                           i_clk,
	input  wire                           i_reset,
	// command FIFO read side
	input  netdbg_pkg::cmd_entry_t        i_entry,
	input  wire                           i_empty,
	output logic                          o_pop,
	// wishbone master
	output netdbg_pkg::wb_req_t           o_wb,
	input  netdbg_pkg::wb_rsp_t           i_wb,
	// gpio inputs, sampled into the reply header
	input  wire [7:0]                     i_gpio,
	// reply stream
	output netdbg_pkg::stream_beat_t      o_rsp,
	output logic                          o_rsp_valid,
	input  wire                           i_rsp_ready
);

	typedef enum logic [1:0] {
		EX_IDLE,
		EX_BUS,
		EX_REPLY,
		EX_FLUSH
	} ex_state_e;

	ex_state_e                        r_state;
	// bus request registers
	logic                             r_cyc;
	logic                             r_stb;
	logic                             r_we;
	logic [netdbg_pkg::ADDR_W-1:0]    r_addr;
	logic [netdbg_pkg::DW-1:0]        r_data;
	logic [WDT_LG-1:0]                r_wdt;
	// reply path
	logic [netdbg_pkg::DW-1:0]        r_pend;
	logic [netdbg_pkg::DW-1:0]        r_rsp_data;
	logic                             r_rsp_last;
	logic                             r_rsp_valid;
	// frame bookkeeping
	logic [15:0]                      r_frame;
	logic [15:0]                      r_prior;
	logic [15:0]                      r_count;
	logic                             w_out_free;
	logic                             w_timeout;
	logic                             w_bus_end;
	logic [netdbg_pkg::DW-1:0]        w_rd_word;

	// output register is free when empty or being taken now
	assign w_out_free = !r_rsp_valid || i_rsp_ready;

	// one entry at a time, and never while a beat is held off
	assign o_pop = (r_state == EX_IDLE) && !i_empty && w_out_free;

	// counter saturates after 2^WDT_LG-1 cycles of cyc
	assign w_timeout = &r_wdt;
	assign w_bus_end = r_cyc && (i_wb.ack || i_wb.err || w_timeout);
	assign w_rd_word = (i_wb.ack && !i_wb.err) ? i_wb.data : netdbg_pkg::ERR_WORD;

	assign o_wb = '{cyc: r_cyc, stb: r_stb, we: r_we, addr: r_addr, data: r_data};
	assign o_rsp = '{data: r_rsp_data, last: r_rsp_last};
	assign o_rsp_valid = r_rsp_valid;

	//////////////////////////////
	// control FSM
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_state <= EX_IDLE;
			r_cyc <= 1'b0;
			r_stb <= 1'b0;
			r_wdt <= '0;
			r_rsp_valid <= 1'b0;
			r_prior <= '0;
			r_count <= '0;
		end
		else
		begin
			// a beat leaves on valid and ready, a load below overrides
			if (r_rsp_valid && i_rsp_ready)
				r_rsp_valid <= 1'b0;
			case (r_state)
			EX_IDLE:
			begin
				if (o_pop)
				begin
					case (i_entry.op)
					netdbg_pkg::CMD_HEADER:
						r_state <= EX_REPLY;
					netdbg_pkg::CMD_END:
					begin
						// pending word goes out marked last
						r_rsp_valid <= 1'b1;
						r_state <= EX_FLUSH;
					end
					default:
					begin
						r_cyc <= 1'b1;
						r_stb <= 1'b1;
						r_state <= EX_BUS;
					end
					endcase
				end
			end
			EX_BUS:
			begin
				// request taken once stall drops
				if (r_stb && !i_wb.stall)
					r_stb <= 1'b0;
				if (w_bus_end)
				begin
					// ack, err or watchdog all close the cycle
					r_cyc <= 1'b0;
					r_stb <= 1'b0;
					r_wdt <= '0;
					r_state <= EX_IDLE;
					if (!r_we)
						r_rsp_valid <= 1'b1;
				end
				else
					r_wdt <= r_wdt + 1'b1;
			end
			EX_REPLY:
			begin
				// second header word pushes the first one out
				if (w_out_free)
				begin
					r_rsp_valid <= 1'b1;
					r_prior <= r_frame;
					r_count <= r_count + 1'b1;
					r_state <= EX_IDLE;
				end
			end
			default:
			begin
				// hold the next packet until the last beat is gone
				if (w_out_free)
					r_state <= EX_IDLE;
			end
			endcase
		end
	end

	//////////////////////////////
	// payload
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (o_pop)
		begin
			case (i_entry.op)
			netdbg_pkg::CMD_HEADER:
			begin
				// word 0 is frame id, gpio in, gpio out
				r_pend <= {i_entry.data[31:16], i_gpio, i_entry.data[7:0]};
				r_frame <= i_entry.data[31:16];
			end
			netdbg_pkg::CMD_END:
			begin
				r_rsp_data <= r_pend;
				r_rsp_last <= 1'b1;
			end
			default:
			begin
				r_we <= (i_entry.op == netdbg_pkg::CMD_WRITE);
				r_addr <= i_entry.addr;
				r_data <= i_entry.data;
			end
			endcase
		end
		if ((r_state == EX_BUS) && w_bus_end && !r_we)
		begin
			// read result replaces pending, old pending is sent
			r_rsp_data <= r_pend;
			r_rsp_last <= 1'b0;
			r_pend <= w_rd_word;
		end
		if ((r_state == EX_REPLY) && w_out_free)
		begin
			r_rsp_data <= r_pend;
			r_rsp_last <= 1'b0;
			r_pend <= {r_prior, r_count};
		end
	end

	// strobe never outside a cycle
	a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		o_wb.stb |-> o_wb.cyc);

	// reply beat held steady under back-pressure
	a_rsp_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_rsp_valid && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp)));

endmodule

`default_nettype wire

// File: rtl/netdbg_top.sv
`timescale 1ns/1ps
`default_nettype none

module netdbg_top #(
	parameter logic [7:0] DEF_GPIO = 8'h00,
	parameter int         LG_FIFO  = 4,
	parameter int         WDT_LG   = 8
) (
	input  wire                           i_clk,
	input  wire                           i_reset,
	// request stream
	input  netdbg_pkg::stream_beat_t      i_req,
	input  wire                           i_req_valid,
	output logic                          o_req_ready,
	// reply stream
	output netdbg_pkg::stream_beat_t      o_rsp,
	output logic                          o_rsp_valid,
	input  wire                           i_rsp_ready,
	// wishbone master
	output netdbg_pkg::wb_req_t           o_wb,
	input  netdbg_pkg::wb_rsp_t           i_wb,
	// gpio
	input  wire [7:0]                     i_gpio,
	output logic [7:0]                    o_gpio
);

	//////////////////////////////
	// parser to FIFO
	//////////////////////////////

	logic                       push;
	logic                       fifo_full;
	netdbg_pkg::cmd_entry_t     push_entry;

	netdbg_parser #(
		.DEF_GPIO(DEF_GPIO)
	) i_parser (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_req(i_req),
		.i_req_valid(i_req_valid),
		.o_req_ready(o_req_ready),
		.o_gpio(o_gpio),
		.o_push(push),
		.o_entry(push_entry),
		.i_full(fifo_full)
	);

	//////////////////////////////
	// FIFO to bus executor
	//////////////////////////////

	logic                       pop;
	logic                       fifo_empty;
	netdbg_pkg::cmd_entry_t     head_entry;

	netdbg_cmd_fifo #(
		.LG_FIFO(LG_FIFO)
	) i_cmd_fifo (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_push(push),
		.i_entry(push_entry),
		.o_full(fifo_full),
		.i_pop(pop),
		.o_entry(head_entry),
		.o_empty(fifo_empty)
	);

	// bus cycles, watchdog and reply assembly
	netdbg_bus_exec #(
		.WDT_LG(WDT_LG)
	) i_bus_exec (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_entry(head_entry),
		.i_empty(fifo_empty),
		.o_pop(pop),
		.o_wb(o_wb),
		.i_wb(i_wb),
		.i_gpio(i_gpio),
		.o_rsp(o_rsp),
		.o_rsp_valid(o_rsp_valid),
		.i_rsp_ready(i_rsp_ready)
	);

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_NS      = 5,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clk,
	output logic o_reset
);

	// 10 ns period
	initial
	begin
		o_clk = 1'b0;
		forever
			#(HALF_NS) o_clk = ~o_clk;
	end

	// reset drops on a falling edge, like every other input
	initial
	begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge o_clk);
		@(negedge o_clk);
		o_reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: test/tb_wb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_memory (
	input  wire                      i_clk,
	input  wire                      i_reset,
	input  netdbg_pkg::wb_req_t      i_wb,
	output netdbg_pkg::wb_rsp_t      o_wb,
	output int                       o_accesses
);

	logic [31:0]            mem [0:255];
	netdbg_pkg::wb_rsp_t    r_rsp = '0;
	// request taken on the last rising edge
	logic                   r_taken = 1'b0;
	logic [29:0]            r_addr = '0;
	int                     r_stall_run = 0;
	int                     r_accesses = 0;

	assign o_wb = r_rsp;
	assign o_accesses = r_accesses;

	//////////////////////////////
	// request side
	//////////////////////////////

	always @(posedge i_clk)
	begin
		r_taken <= 1'b0;
		if (i_reset)
		begin
			r_accesses <= 0;
			// fill pattern built from the whole word index
			for (int i = 0; i < 256; i++)
				mem[i] <= {8'hA5, 8'(i), ~8'(i), 8'(i) ^ 8'h3C};
		end
		else if (i_wb.cyc && i_wb.stb && !r_rsp.stall)
		begin
			r_taken <= 1'b1;
			r_addr <= i_wb.addr;
			r_accesses <= r_accesses + 1;
			// only the plain region stores anything
			if (i_wb.we && (i_wb.addr[29:28] == 2'b00))
				mem[i_wb.addr[7:0]] <= i_wb.data;
		end
	end

	//////////////////////////////
	// response side
	//////////////////////////////

	// outputs change on the falling edge
	always @(negedge i_clk)
	begin
		r_rsp.ack = 1'b0;
		r_rsp.err = 1'b0;
		r_rsp.data = '0;
		if (r_taken && i_wb.cyc)
		begin
			// bit 29 answers err, bit 28 alone never answers
			if (r_addr[29])
				r_rsp.err = 1'b1;
			else if (!r_addr[28])
			begin
				r_rsp.ack = 1'b1;
				r_rsp.data = mem[r_addr[7:0]];
			end
		end
		// random stall, at most 3 cycles in a row so plain accesses beat the watchdog
		if ((r_stall_run < 3) && ($urandom_range(0, 3) == 0))
		begin
			r_rsp.stall = 1'b1;
			r_stall_run = r_stall_run + 1;
		end
		else
		begin
			r_rsp.stall = 1'b0;
			r_stall_run = 0;
		end
	end

endmodule

`default_nettype wire

// File: test/tb_netdbg.sv
`timescale 1ns/1ps
`default_nettype none

module tb_netdbg;

	//////////////////////////////
	// run sizing
	//////////////////////////////

	localparam logic [7:0] DEF_GPIO = 8'hA5;
	localparam int WDT_LG = 6;
	localparam int BATCHES = 4;
	localparam int PKTS_PER_BATCH = 5;
	// command words after the header, at most
	localparam int MAX_WORDS = 8;
	// every word might be an access that runs into the bus watchdog
	localparam int WORST_PKT_CYCLES = MAX_WORDS * ((1 << WDT_LG) + 8) + 64;
	localparam int WORST_RUN_NS = BATCHES * PKTS_PER_BATCH * WORST_PKT_CYCLES * 10;
	localparam int TIMEOUT_NS = 200_000;
	localparam logic [31:0] BAD_READ = 32'hDEADBEEF;

	logic                        clk;
	logic                        reset;
	netdbg_pkg::stream_beat_t    req_beat;
	logic                        req_valid;
	logic                        req_ready;
	netdbg_pkg::stream_beat_t    rsp_beat;
	logic                        rsp_valid;
	logic                        rsp_ready;
	netdbg_pkg::wb_req_t         wb_req;
	netdbg_pkg::wb_rsp_t         wb_rsp;
	logic [7:0]                  gpio_in;
	logic [7:0]                  gpio_out;
	int                          mem_accesses;

	// reference model state
	logic [31:0]    model_mem [0:255];
	logic [7:0]     model_gpio;
	logic [29:0]    model_addr;
	logic [15:0]    model_prior;
	logic [15:0]    model_count;
	int             model_accesses;
	logic [31:0]    exp_data [$];
	logic           exp_last [$];
	int             errors;
	int             checks;
	int             packets;

	tb_clock i_clock (
		.o_clk(clk),
		.o_reset(reset)
	);

	netdbg_top #(
		.DEF_GPIO(DEF_GPIO),
		.LG_FIFO(4),
		.WDT_LG(WDT_LG)
	) i_netdbg_top (
		.i_clk(clk),
		.i_reset(reset),
		.i_req(req_beat),
		.i_req_valid(req_valid),
		.o_req_ready(req_ready),
		.o_rsp(rsp_beat),
		.o_rsp_valid(rsp_valid),
		.i_rsp_ready(rsp_ready),
		.o_wb(wb_req),
		.i_wb(wb_rsp),
		.i_gpio(gpio_in),
		.o_gpio(gpio_out)
	);

	tb_wb_memory i_memory (
		.i_clk(clk),
		.i_reset(reset),
		.i_wb(wb_req),
		.o_wb(wb_rsp),
		.o_accesses(mem_accesses)
	);

	//////////////////////////////
	// model helpers
	//////////////////////////////

	function automatic logic [31:0] fill_word(input logic [7:0] idx);
		return {8'hA5, idx, ~idx, idx ^ 8'h3C};
	endfunction

	// mostly plain addresses near zero, some error and silent ones
	function automatic logic [29:0] pick_address();
		int pick;
		pick = $urandom_range(0, 15);
		if (pick == 0)
			return {2'b01, 28'($urandom)};
		else if (pick < 3)
			return {1'b1, 29'($urandom)};
		else
			return {2'b00, 20'($urandom), 8'($urandom_range(0, 15))};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		errors++;
		$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, want);
	endtask

	// one bus access, then the address moves on
	task automatic predict_access(input logic is_write, input logic [31:0] wdata,
			output logic [31:0] rdata);
		// error and silent regions both read back as the error word
		rdata = BAD_READ;
		model_accesses++;
		if (model_addr[29:28] == 2'b00)
		begin
			if (is_write)
				model_mem[model_addr[7:0]] = wdata;
			else
				rdata = model_mem[model_addr[7:0]];
		end
		model_addr = model_addr + 30'd1;
	endtask

	//////////////////////////////
	// request and reply streams
	//////////////////////////////

	// called on a falling edge, returns on the falling edge after the beat moved
	task automatic send_word(input logic [31:0] data, input logic last);
		req_beat.data = data;
		req_beat.last = last;
		req_valid = 1'b1;
		while (!req_ready)
			@(negedge clk);
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic run_packet();
		logic [31:0]    words [$];
		logic [31:0]    reply [$];
		logic [15:0]    frame;
		logic [7:0]     mask;
		logic [7:0]     vals;
		logic [31:0]    wdata;
		logic [31:0]    rdata;
		int             n_words;
		int             kind;
		frame = 16'($urandom);
		mask = 8'($urandom);
		vals = 8'($urandom);
		words.push_back({frame, mask, vals});
		// masked bits take the new value
		for (int i = 0; i < 8; i++)
		begin
			if (mask[i])
				model_gpio[i] = vals[i];
		end
		reply.push_back({frame, gpio_in, model_gpio});
		reply.push_back({model_prior, model_count});
		model_prior = frame;
		model_count = model_count + 16'd1;
		n_words = $urandom_range(0, MAX_WORDS);
		while (words.size() < n_words + 1)
		begin
			kind = $urandom_range(0, 9);
			if (kind < 2)
			begin
				model_addr = pick_address();
				words.push_back({2'b00, model_addr});
			end
			else if (kind < 5)
			begin
				words.push_back({2'b01, 30'($urandom)});
				// a write as the final word has no data and is dropped
				if (words.size() < n_words + 1)
				begin
					wdata = $urandom;
					words.push_back(wdata);
					predict_access(1'b1, wdata, rdata);
				end
			end
			else if (kind < 9)
			begin
				words.push_back({2'b10, 30'($urandom)});
				predict_access(1'b0, 32'h0, rdata);
				reply.push_back(rdata);
			end
			else
				words.push_back({2'b11, 30'($urandom)});
		end
		foreach (reply[i])
		begin
			exp_data.push_back(reply[i]);
			exp_last.push_back(i == reply.size() - 1);
		end
		packets++;
		foreach (words[i])
		begin
			// occasional idle cycle between words
			if ($urandom_range(0, 3) == 0)
				@(negedge clk);
			send_word(words[i], i == words.size() - 1);
			if (i == 0)
			begin
				checks++;
				if (gpio_out !== model_gpio)
					report_mismatch("o_gpio", 32'(gpio_out), 32'(model_gpio));
			end
		end
	endtask

	// higher level means ready is low more often
	task automatic receive_replies(input int count, input int level);
		logic [31:0]    want_data;
		logic           want_last;
		logic           ready;
		int             done;
		done = 0;
		while (done < count)
		begin
			@(negedge clk);
			ready = ($urandom_range(0, 3) >= level);
			rsp_ready = ready;
			// beat moves on the coming rising edge
			if (rsp_valid && ready)
			begin
				if (exp_data.size() == 0)
				begin
					errors++;
					$display("Fail at %0t ns: reply beat %h came with nothing expected",
						$time, rsp_beat.data);
				end
				else
				begin
					want_data = exp_data.pop_front();
					want_last = exp_last.pop_front();
					checks += 2;
					if (rsp_beat.data !== want_data)
						report_mismatch("o_rsp.data", rsp_beat.data, want_data);
					if (rsp_beat.last !== want_last)
						report_mismatch("o_rsp.last", 32'(rsp_beat.last), 32'(want_last));
				end
				if (rsp_beat.last)
					done++;
			end
		end
		// let the final beat go through
		@(negedge clk);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial
	begin
		void'($urandom(48353));
		errors = 0;
		checks = 0;
		packets = 0;
		req_beat = '0;
		req_valid = 1'b0;
		rsp_ready = 1'b0;
		gpio_in = 8'h00;
		model_gpio = DEF_GPIO;
		model_addr = '0;
		model_prior = '0;
		model_count = '0;
		model_accesses = 0;
		for (int i = 0; i < 256; i++)
			model_mem[i] = fill_word(8'(i));
		$display("worst case run %0d ns, watchdog at %0d ns", WORST_RUN_NS, TIMEOUT_NS);

		// outputs while reset is held
		@(posedge clk);
		@(negedge clk);
		checks += 4;
		if (req_ready !== 1'b0)
			report_mismatch("o_req_ready", 32'(req_ready), 32'h0);
		if (rsp_valid !== 1'b0)
			report_mismatch("o_rsp_valid", 32'(rsp_valid), 32'h0);
		if (wb_req.cyc !== 1'b0)
			report_mismatch("o_wb.cyc", 32'(wb_req.cyc), 32'h0);
		if (gpio_out !== DEF_GPIO)
			report_mismatch("o_gpio", 32'(gpio_out), 32'(DEF_GPIO));
		wait (!reset);

		for (int b = 0; b < BATCHES; b++)
		begin
			@(negedge clk);
			// gpio inputs only change while the bridge is drained
			gpio_in = 8'($urandom);
			fork
				begin
					for (int p = 0; p < PKTS_PER_BATCH; p++)
						run_packet();
				end
				receive_replies(PKTS_PER_BATCH, b);
			join
			// no-ops and dropped writes must not reach the bus
			checks++;
			if (mem_accesses != model_accesses)
				report_mismatch("bus access count", mem_accesses, model_accesses);
		end

		checks++;
		if (exp_data.size() != 0)
		begin
			errors++;
			$display("%0d reply words never arrived", exp_data.size());
		end

		$display("packets %0d, checks %0d, errors %0d", packets, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// hang guard
	initial
	begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns with the run unfinished", TIMEOUT_NS);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
rtl/netdbg_pkg.sv
rtl/netdbg_parser.sv
rtl/netdbg_cmd_fifo.sv
rtl/netdbg_bus_exec.sv
rtl/netdbg_top.sv
test/tb_clock.sv
test/tb_wb_memory.sv
test/tb_netdbg.sv

// File: run_sim.sh
#!/bin/sh
# build the netdbg testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_netdbg -f sim.f -o tb_netdbg
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_netdbg > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
	echo "no pass line found in $LOG"
	exit 1
fi
exit 0
